// ==== rdp_defs.svh ====
// Read path widths and thresholds
`ifndef RDP_DEFS_SVH
`define RDP_DEFS_SVH

// One half-rate AFI read word covers every DQS group and every beat
`define RDP_AFI_DATA_WIDTH 32
`define RDP_NUM_DQS 2
`define RDP_DQS_DATA_WIDTH 4
`define RDP_BEATS 4

// Number of valid bits presented to the controller per AFI cycle
`define RDP_AFI_RATE_RATIO 2

// Valid prediction shift register length and its lowest usable tap
`define RDP_MAX_READ_LATENCY 16
`define RDP_VFIFO_OFFSET 8

// Resync FIFO holds 2**ADDR_WIDTH words
`define RDP_FIFO_ADDR_WIDTH 3

// Start-up counter values that must be exceeded before writes, then reads, begin
`define RDP_WR_START 6
`define RDP_RD_START 10

// Wishbone word address bits of the register block
`define RDP_WB_ADR_WIDTH 2

`endif

// ==== rdp_pkg.sv ====
// Read path shared types
`include "rdp_defs.svh"

package rdp_pkg;

    // Full AFI read word, group-major on the FIFO side and beat-major at the AFI
    typedef logic [`RDP_AFI_DATA_WIDTH-1:0] afi_data_t;

    // Per-slot read valid vector
    typedef logic [`RDP_AFI_RATE_RATIO-1:0] afi_valid_t;

    // Tap pointer, wide enough to walk every tap above the fixed offset
    typedef logic [$clog2(`RDP_MAX_READ_LATENCY - `RDP_VFIFO_OFFSET)-1:0] vfifo_ptr_t;

    // Wishbone data and word address
    typedef logic [31:0] wb_data_t;
    typedef logic [`RDP_WB_ADR_WIDTH-1:0] wb_adr_t;

    // FIFO start-up sequence
    // Counting with both sides idle, then writing only, then reading as well
    typedef enum logic [1:0] {
        FS_COUNT,
        FS_WRITE,
        FS_RUN
    } fifo_start_e;

endpackage

// ==== read_valid_predictor.sv ====
// Read valid predictor
`timescale 1ns/1ps
`include "rdp_defs.svh"

module read_valid_predictor (
    input  logic                pll_afi_clk,
    input  logic                reset_n_afi_clk,
    input  logic                rdata_en,
    input  rdp_pkg::vfifo_ptr_t vfifo_pointer,
    output rdp_pkg::afi_valid_t rdata_valid
);

    localparam int IDX_W = $clog2(`RDP_MAX_READ_LATENCY);

    logic                             rdata_en_q;
    logic [`RDP_MAX_READ_LATENCY-1:0] vfifo_shift;
    logic [IDX_W-1:0]                 tap_idx;
    logic                             tap_bit;

    // Capture flop for the read enable
    // Its edge is the reference point of the read latency
    // Stage N of the shift register then holds the enable from N+1 cycles back
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            rdata_en_q  <= 1'b0;
            vfifo_shift <= '0;
        end
        else
        begin
            rdata_en_q  <= rdata_en;
            vfifo_shift <= {vfifo_shift[`RDP_MAX_READ_LATENCY-2:0], rdata_en_q};
        end
    end

    // Calibration moves the tap between offset and offset plus 7
    assign tap_idx = IDX_W'(`RDP_VFIFO_OFFSET) + IDX_W'(vfifo_pointer);
    assign tap_bit = vfifo_shift[tap_idx];

    // Both slots of the half-rate word carry the same prediction
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            rdata_valid <= '0;
        else
            rdata_valid <= {`RDP_AFI_RATE_RATIO{tap_bit}};
    end

endmodule

// ==== rdata_dcfifo.sv ====
// Dual-clock read data FIFO
`timescale 1ns/1ps

module rdata_dcfifo #(
    parameter int WIDTH      = 32,
    parameter int ADDR_WIDTH = 3
) (
    input  logic             wr_clk,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_clk,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    input  logic             aclr_n,
    output logic             full,
    output logic             empty
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [ADDR_WIDTH:0] wr_bin;
    logic [ADDR_WIDTH:0] wr_bin_next;
    logic [ADDR_WIDTH:0] wr_gray;
    logic [ADDR_WIDTH:0] rd_bin;
    logic [ADDR_WIDTH:0] rd_bin_next;
    logic [ADDR_WIDTH:0] rd_gray;
    logic [ADDR_WIDTH:0] rd_gray_sync1;
    logic [ADDR_WIDTH:0] rd_gray_sync2;
    logic [ADDR_WIDTH:0] wr_gray_sync1;
    logic [ADDR_WIDTH:0] wr_gray_sync2;
    logic                wr_fire;
    logic                rd_fire;

    // Requests against a full or empty FIFO are dropped here
    assign wr_fire     = wr_en & ~full;
    assign rd_fire     = rd_en & ~empty;
    assign wr_bin_next = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_fire};
    assign rd_bin_next = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_fire};

    // Write side pointers, with the read pointer brought over in Gray code
    always_ff @(posedge wr_clk or negedge aclr_n)
    begin
        if (!aclr_n)
        begin
            wr_bin        <= '0;
            wr_gray       <= '0;
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end
        else
        begin
            wr_bin        <= wr_bin_next;
            wr_gray       <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_sync1 <= rd_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    always_ff @(posedge wr_clk)
    begin
        if (wr_fire)
            mem[wr_bin[ADDR_WIDTH-1:0]] <= wr_data;
    end

    // Full when the write pointer has lapped the read pointer once
    // In Gray code that flips the two upper bits
    assign full = (wr_gray == {~rd_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                               rd_gray_sync2[ADDR_WIDTH-2:0]});

    // Read side pointers, with the write pointer brought over in Gray code
    always_ff @(posedge rd_clk or negedge aclr_n)
    begin
        if (!aclr_n)
        begin
            rd_bin        <= '0;
            rd_gray       <= '0;
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end
        else
        begin
            rd_bin        <= rd_bin_next;
            rd_gray       <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_sync1 <= wr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    assign empty = (rd_gray == wr_gray_sync2);

    // Registered output word, held while no read is made
    always_ff @(posedge rd_clk)
    begin
        if (rd_fire)
            rd_data <= mem[rd_bin[ADDR_WIDTH-1:0]];
    end

endmodule

// ==== read_datapath.sv ====
// Half-rate read datapath
`timescale 1ns/1ps
`include "rdp_defs.svh"

module read_datapath (
    input  logic                pll_afi_clk,
    input  logic                reset_n_afi_clk,
    input  logic                read_capture_clk_hr_dq,
    input  rdp_pkg::afi_data_t  rdata_hr,
    input  rdp_pkg::afi_valid_t afi_rdata_en,
    input  logic                seq_read_fifo_reset,
    input  rdp_pkg::vfifo_ptr_t vfifo_pointer,
    output rdp_pkg::afi_data_t  afi_rdata,
    output rdp_pkg::afi_valid_t afi_rdata_valid,
    output logic                fifo_reading
);
    import rdp_pkg::*;

    fifo_start_e start_state;
    logic [3:0]  start_count;
    logic        fifo_clear;
    logic        fifo_aclr_n;
    logic        fifo_wr_req;
    logic [1:0]  wr_en_sync;
    logic        fifo_full;
    logic        fifo_empty;
    afi_data_t   fifo_rdata;

    // Start-up sequencer, restarted by a sequencer FIFO reset pulse
    // Writes open first so that reads find a cushion of words waiting
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            start_state <= FS_COUNT;
            start_count <= '0;
            fifo_clear  <= 1'b0;
        end
        else
        begin
            fifo_clear <= seq_read_fifo_reset;
            if (seq_read_fifo_reset)
            begin
                start_state <= FS_COUNT;
                start_count <= '0;
            end
            else
            begin
                // Saturates once the FIFO is running
                if (!(&start_count))
                    start_count <= start_count + 1'b1;
                case (start_state)
                    FS_COUNT:
                        if (start_count > 4'(`RDP_WR_START))
                            start_state <= FS_WRITE;
                    FS_WRITE:
                        if (start_count > 4'(`RDP_RD_START))
                            start_state <= FS_RUN;
                    FS_RUN:
                        start_state <= FS_RUN;
                    default:
                        start_state <= FS_COUNT;
                endcase
            end
        end
    end

    assign fifo_wr_req  = (start_state != FS_COUNT);
    assign fifo_reading = (start_state == FS_RUN);

    // The FIFO is cleared for one AFI cycle after a reset pulse
    assign fifo_aclr_n = reset_n_afi_clk & ~fifo_clear;

    // Write enable crosses into the capture clock domain
    always_ff @(posedge read_capture_clk_hr_dq or negedge fifo_aclr_n)
    begin
        if (!fifo_aclr_n)
            wr_en_sync <= '0;
        else
            wr_en_sync <= {wr_en_sync[0], fifo_wr_req};
    end

    rdata_dcfifo #(
        .WIDTH      (`RDP_AFI_DATA_WIDTH),
        .ADDR_WIDTH (`RDP_FIFO_ADDR_WIDTH)
    ) rdata_fifo_inst (
        .wr_clk  (read_capture_clk_hr_dq),
        .wr_en   (wr_en_sync[1]),
        .wr_data (rdata_hr),
        .rd_clk  (pll_afi_clk),
        .rd_en   (fifo_reading),
        .rd_data (fifo_rdata),
        .aclr_n  (fifo_aclr_n),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // Group-major FIFO word to beat-major AFI word
    for (genvar g = 0; g < `RDP_NUM_DQS; g++)
    begin : g_group
        for (genvar b = 0; b < `RDP_BEATS; b++)
        begin : g_beat
            assign afi_rdata[(b*`RDP_NUM_DQS+g)*`RDP_DQS_DATA_WIDTH +: `RDP_DQS_DATA_WIDTH] =
                fifo_rdata[(g*`RDP_BEATS+b)*`RDP_DQS_DATA_WIDTH +: `RDP_DQS_DATA_WIDTH];
        end
    end

    // Only slot 0 of the read enable drives the prediction
    read_valid_predictor read_valid_predictor_inst (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .rdata_en        (afi_rdata_en[0]),
        .vfifo_pointer   (vfifo_pointer),
        .rdata_valid     (afi_rdata_valid)
    );

endmodule

// ==== seq_csr.sv ====
// Sequencer register block
`timescale 1ns/1ps

module seq_csr (
    input  logic                pll_afi_clk,
    input  logic                reset_n_afi_clk,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  rdp_pkg::wb_adr_t    wb_adr,
    input  rdp_pkg::wb_data_t   wb_dat_w,
    output rdp_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack,
    input  logic                fifo_reading,
    output logic                seq_read_increment_vfifo,
    output logic                seq_read_fifo_reset,
    output rdp_pkg::vfifo_ptr_t vfifo_pointer
);
    import rdp_pkg::*;

    localparam wb_adr_t CTRL_ADR   = wb_adr_t'(0);
    localparam wb_adr_t STATUS_ADR = wb_adr_t'(1);

    logic     wb_req;
    logic     ack_served;
    logic     ctrl_write;
    wb_data_t status_word;

    assign wb_req = wb_cyc & wb_stb;

    // Single-cycle ack per strobe
    // A held strobe gets no second ack until it has been dropped
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            wb_ack     <= 1'b0;
            ack_served <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req & ~wb_ack & ~ack_served;
            if (wb_ack)
                ack_served <= 1'b1;
            else if (!wb_stb)
                ack_served <= 1'b0;
        end
    end

    // CTRL writes land in the ack cycle and become one-cycle pulses
    assign ctrl_write               = wb_ack & wb_req & wb_we & (wb_adr == CTRL_ADR);
    assign seq_read_increment_vfifo = ctrl_write & wb_dat_w[0];
    assign seq_read_fifo_reset      = ctrl_write & wb_dat_w[1];

    // Pointer wraps modulo its width
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            vfifo_pointer <= '0;
        else if (seq_read_increment_vfifo)
            vfifo_pointer <= vfifo_pointer + 1'b1;
    end

    // STATUS holds the pointer in the low bits and the read state in bit 8
    always_comb
    begin
        status_word = '0;
        status_word[$bits(vfifo_ptr_t)-1:0] = vfifo_pointer;
        status_word[8] = fifo_reading;
    end

    // Unmapped addresses read as zero
    assign wb_dat_r = (wb_adr == STATUS_ADR) ? status_word : '0;

endmodule

// ==== emif_read_path_top.sv ====
// Read path top level
`timescale 1ns/1ps

module emif_read_path_top (
    input  logic                pll_afi_clk,
    input  logic                reset_n_afi_clk,
    input  logic                read_capture_clk_hr_dq,
    input  rdp_pkg::afi_data_t  rdata_hr,
    input  rdp_pkg::afi_valid_t afi_rdata_en,
    output rdp_pkg::afi_data_t  afi_rdata,
    output rdp_pkg::afi_valid_t afi_rdata_valid,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  rdp_pkg::wb_adr_t    wb_adr,
    input  rdp_pkg::wb_data_t   wb_dat_w,
    output rdp_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack
);
    import rdp_pkg::*;

    logic       seq_read_fifo_reset;
    logic       fifo_reading;
    vfifo_ptr_t vfifo_pointer;

    // The step pulse is consumed inside the register block, which owns the pointer
    seq_csr seq_csr_inst (
        .pll_afi_clk              (pll_afi_clk),
        .reset_n_afi_clk          (reset_n_afi_clk),
        .wb_cyc                   (wb_cyc),
        .wb_stb                   (wb_stb),
        .wb_we                    (wb_we),
        .wb_adr                   (wb_adr),
        .wb_dat_w                 (wb_dat_w),
        .wb_dat_r                 (wb_dat_r),
        .wb_ack                   (wb_ack),
        .fifo_reading             (fifo_reading),
        .seq_read_increment_vfifo (),
        .seq_read_fifo_reset      (seq_read_fifo_reset),
        .vfifo_pointer            (vfifo_pointer)
    );

    read_datapath read_datapath_inst (
        .pll_afi_clk            (pll_afi_clk),
        .reset_n_afi_clk        (reset_n_afi_clk),
        .read_capture_clk_hr_dq (read_capture_clk_hr_dq),
        .rdata_hr               (rdata_hr),
        .afi_rdata_en           (afi_rdata_en),
        .seq_read_fifo_reset    (seq_read_fifo_reset),
        .vfifo_pointer          (vfifo_pointer),
        .afi_rdata              (afi_rdata),
        .afi_rdata_valid        (afi_rdata_valid),
        .fifo_reading           (fifo_reading)
    );

endmodule

// ==== read_path_assertions.sv ====
// Read path assertions
`timescale 1ns/1ps

module read_path_assertions (
    input logic                pll_afi_clk,
    input logic                reset_n_afi_clk,
    input logic                wr_clk,
    input logic                wb_stb,
    input logic                wb_ack,
    input rdp_pkg::afi_valid_t rdata_valid,
    input logic                fifo_wr_en,
    input logic                fifo_full,
    input logic                fifo_rd_en,
    input logic                fifo_empty
);

    // Ack may only answer a strobe that is still present
    ack_needs_stb: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        wb_ack |-> wb_stb)
        else $error("wb_ack high while wb_stb is low");

    // Both half-rate slots carry one prediction
    valid_bits_equal: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        rdata_valid[0] == rdata_valid[1])
        else $error("afi_rdata_valid bits differ");

    // The cushion keeps the FIFO away from both ends
    no_write_when_full: assert property (@(posedge wr_clk) disable iff (!reset_n_afi_clk)
        !(fifo_wr_en && fifo_full))
        else $error("FIFO write attempted while full");

    no_read_when_empty: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        !(fifo_rd_en && fifo_empty))
        else $error("FIFO read attempted while empty");

endmodule

// ==== tb_read_path.sv ====
// Read path testbench
`timescale 1ns/1ps
`include "rdp_defs.svh"

module tb_read_path;
    import rdp_pkg::*;

    // Rough length of each test in AFI cycles, used to size the watchdog
    localparam int RESET_CYCLES = 8;
    localparam int T1_CYCLES    = 40;
    localparam int T2_CYCLES    = 200;
    localparam int T3_CYCLES    = 8 * 90;
    localparam int T4_CYCLES    = 400;
    localparam int T5_CYCLES    = 500;
    localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES + 20;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 500) * 10;
    localparam int VALID_BASE   = `RDP_VFIFO_OFFSET + 2;

    logic       pll_afi_clk;
    logic       reset_n_afi_clk;
    logic       read_capture_clk_hr_dq;
    afi_data_t  rdata_hr;
    afi_valid_t afi_rdata_en;
    afi_data_t  afi_rdata;
    afi_valid_t afi_rdata_valid;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    integer    seed = 32'hd299790f;
    int        errors;
    int        checks;
    int        afi_cyc;
    int        ptr_model;
    logic      en_random;
    logic      valid_check_on;
    logic      en_ring [0:31];
    afi_data_t data_q [$];

    emif_read_path_top emif_read_path_top_inst (
        .pll_afi_clk            (pll_afi_clk),
        .reset_n_afi_clk        (reset_n_afi_clk),
        .read_capture_clk_hr_dq (read_capture_clk_hr_dq),
        .rdata_hr               (rdata_hr),
        .afi_rdata_en           (afi_rdata_en),
        .afi_rdata              (afi_rdata),
        .afi_rdata_valid        (afi_rdata_valid),
        .wb_cyc                 (wb_cyc),
        .wb_stb                 (wb_stb),
        .wb_we                  (wb_we),
        .wb_adr                 (wb_adr),
        .wb_dat_w               (wb_dat_w),
        .wb_dat_r               (wb_dat_r),
        .wb_ack                 (wb_ack)
    );

    // Datapath instance checks the valid bits and both FIFO ends
    bind read_datapath read_path_assertions datapath_checks (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .wr_clk          (read_capture_clk_hr_dq),
        .wb_stb          (1'b0),
        .wb_ack          (1'b0),
        .rdata_valid     (afi_rdata_valid),
        .fifo_wr_en      (wr_en_sync[1]),
        .fifo_full       (fifo_full),
        .fifo_rd_en      (fifo_reading),
        .fifo_empty      (fifo_empty)
    );

    // Register block instance checks only the Wishbone ack
    bind seq_csr read_path_assertions csr_checks (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .wr_clk          (pll_afi_clk),
        .wb_stb          (wb_stb),
        .wb_ack          (wb_ack),
        .rdata_valid     (2'b00),
        .fifo_wr_en      (1'b0),
        .fifo_full       (1'b0),
        .fifo_rd_en      (1'b0),
        .fifo_empty      (1'b0)
    );

    initial pll_afi_clk = 1'b0;
    always #5 pll_afi_clk = ~pll_afi_clk;

    // Capture clock has the AFI period and rises 3 ns later
    initial
    begin
        read_capture_clk_hr_dq = 1'b0;
        #3;
        forever #5 read_capture_clk_hr_dq = ~read_capture_clk_hr_dq;
    end

    // Every capture word goes into the model queue, which keeps only recent words
    always @(negedge read_capture_clk_hr_dq)
    begin
        rdata_hr = $random(seed);
        data_q.push_back(rdata_hr);
        if (data_q.size() > 64)
            void'(data_q.pop_front());
    end

    // Random read enables when the test asks for them
    always @(negedge pll_afi_clk)
    begin
        if (en_random)
            afi_rdata_en = afi_valid_t'($random(seed));
        else
            afi_rdata_en = '0;
    end

    // Edge n stores the enable it samples at ring slot n
    always @(posedge pll_afi_clk)
    begin
        afi_cyc = afi_cyc + 1;
        en_ring[afi_cyc % 32] = afi_rdata_en[0];
    end

    // Valid after edge n is the enable of edge n - pointer - offset - 2
    always @(negedge pll_afi_clk)
    begin : valid_check
        int   src;
        logic exp_valid;
        if (valid_check_on)
        begin
            src = afi_cyc - VALID_BASE - ptr_model;
            exp_valid = (src > 0) ? en_ring[src % 32] : 1'b0;
            checks++;
            if (afi_rdata_valid[0] !== afi_rdata_valid[1])
            begin
                errors++;
                $display("ERR @%0t: afi_rdata_valid bits differ, %b", $time, afi_rdata_valid);
            end
            else if (afi_rdata_valid[0] !== exp_valid)
            begin
                errors++;
                $display("ERR @%0t: afi_rdata_valid %b, expected %b with pointer %0d",
                         $time, afi_rdata_valid[0], exp_valid, ptr_model);
            end
        end
    end

    // Group-major capture word to beat-major AFI word, one nibble at a time
    function automatic afi_data_t reorder_word(input afi_data_t w);
        afi_data_t r;
        int        s;
        int        grp;
        int        beat;
        r = '0;
        for (s = 0; s < `RDP_NUM_DQS * `RDP_BEATS; s++)
        begin
            grp  = s % `RDP_NUM_DQS;
            beat = s / `RDP_NUM_DQS;
            r[s*`RDP_DQS_DATA_WIDTH +: `RDP_DQS_DATA_WIDTH] =
                w[(grp*`RDP_BEATS+beat)*`RDP_DQS_DATA_WIDTH +: `RDP_DQS_DATA_WIDTH];
        end
        return r;
    endfunction

    // Classic cycle, strobe held through the edge that samples ack
    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited = 0;
        @(negedge pll_afi_clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge pll_afi_clk);
        while (!wb_ack && waited < 20)
        begin
            @(negedge pll_afi_clk);
            waited++;
        end
        if (!wb_ack)
        begin
            errors++;
            $display("Wishbone access to address %0d got no ack by %0t", adr, $time);
        end
        rdata = wb_dat_r;
        @(negedge pll_afi_clk);
        checks++;
        if (wb_ack)
        begin
            errors++;
            $display("ERR @%0t: wb_ack stayed high for more than one cycle", $time);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_status(output wb_data_t st);
        wb_access(1'b0, wb_adr_t'(1), '0, st);
    endtask

    task automatic write_ctrl(input wb_data_t value);
        wb_data_t ignored;
        wb_access(1'b1, wb_adr_t'(0), value, ignored);
    endtask

    // STATUS must hold the model pointer and nothing beside the read flag
    task automatic check_status_ptr();
        wb_data_t st;
        read_status(st);
        checks++;
        if ((st & ~32'h0000_0100) !== wb_data_t'(ptr_model))
        begin
            errors++;
            $display("ERR @%0t: STATUS 0x%08h, expected pointer %0d", $time, st, ptr_model);
        end
    endtask

    // Polls STATUS until the read flag takes the wanted value
    task automatic wait_reads(input logic want);
        wb_data_t st;
        int       polls;
        polls = 0;
        read_status(st);
        while (st[8] !== want && polls < 40)
        begin
            read_status(st);
            polls++;
        end
        if (st[8] !== want)
        begin
            errors++;
            $display("STATUS read flag never became %b by %0t", want, $time);
        end
    endtask

    // Finds the output word in the queue, then follows the queue word by word
    task automatic check_stream(input int n_words);
        int        waited;
        int        idx;
        int        i;
        int        n;
        logic      found;
        afi_data_t exp_word;
        found  = 1'b0;
        waited = 0;
        idx    = 0;
        while (!found && waited < 40)
        begin
            @(negedge pll_afi_clk);
            waited++;
            for (i = 0; i < data_q.size(); i++)
            begin
                if (!found && reorder_word(data_q[i]) === afi_rdata)
                begin
                    found = 1'b1;
                    idx   = i;
                end
            end
        end
        if (!found)
        begin
            errors++;
            $display("afi_rdata never matched a driven capture word by %0t", $time);
        end
        else
        begin
            for (i = 0; i <= idx; i++)
                void'(data_q.pop_front());
            for (n = 0; n < n_words; n++)
            begin
                @(negedge pll_afi_clk);
                checks++;
                if (data_q.size() == 0)
                begin
                    errors++;
                    $display("ERR @%0t: afi_rdata %h with no word left in the model",
                             $time, afi_rdata);
                end
                else
                begin
                    exp_word = reorder_word(data_q.pop_front());
                    if (afi_rdata !== exp_word)
                    begin
                        errors++;
                        $display("ERR @%0t: afi_rdata %h, expected %h",
                                 $time, afi_rdata, exp_word);
                    end
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    initial
    begin : main
        wb_data_t st;
        int       e0;
        int       step;
        int       i;
        reset_n_afi_clk = 1'b0;
        rdata_hr        = '0;
        afi_rdata_en    = '0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        errors          = 0;
        checks          = 0;
        afi_cyc         = 0;
        ptr_model       = 0;
        en_random       = 1'b0;
        valid_check_on  = 1'b0;
        for (i = 0; i < 32; i++)
            en_ring[i] = 1'b0;

        // Test 1, outputs held low through reset and pointer zero after it
        e0 = errors;
        repeat (RESET_CYCLES)
        begin
            @(negedge pll_afi_clk);
            checks++;
            if (afi_rdata_valid !== '0 || wb_ack !== 1'b0)
            begin
                errors++;
                $display("ERR @%0t: valid %b ack %b during reset",
                         $time, afi_rdata_valid, wb_ack);
            end
        end
        reset_n_afi_clk = 1'b1;
        valid_check_on  = 1'b1;
        repeat (2) @(negedge pll_afi_clk);
        check_status_ptr();
        report_test("test 1 reset state", e0);

        // Test 2, random enables at pointer zero
        e0 = errors;
        en_random = 1'b1;
        repeat (T2_CYCLES) @(negedge pll_afi_clk);
        report_test("test 2 valid latency at pointer 0", e0);

        // Test 3, every step made with the shift register drained, so the model
        // pointer may change at any point of the quiet window
        e0 = errors;
        for (step = 1; step <= 8; step++)
        begin
            en_random = 1'b0;
            repeat (20) @(negedge pll_afi_clk);
            write_ctrl(32'h1);
            ptr_model = (ptr_model + 1) % 8;
            check_status_ptr();
            en_random = 1'b1;
            repeat (60) @(negedge pll_afi_clk);
        end
        report_test("test 3 pointer stepping and wrap", e0);

        // Test 4, data stream in order once reads run
        e0 = errors;
        wait_reads(1'b1);
        check_stream(200);
        report_test("test 4 read data order", e0);

        // Test 5, FIFO reset while enables keep running
        e0 = errors;
        write_ctrl(32'h2);
        data_q.delete();
        read_status(st);
        checks++;
        if (st[8] !== 1'b0)
        begin
            errors++;
            $display("ERR @%0t: STATUS 0x%08h shows reads running after FIFO reset", $time, st);
        end
        wait_reads(1'b1);
        check_stream(200);
        report_test("test 5 FIFO reset and realign", e0);

        en_random = 1'b0;
        repeat (20) @(negedge pll_afi_clk);
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog sized from the test lengths plus a margin
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
rdp_pkg.sv
read_valid_predictor.sv
rdata_dcfifo.sv
read_datapath.sv
seq_csr.sv
emif_read_path_top.sv
read_path_assertions.sv
tb_read_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the read path simulation with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_read_path -f list.f --Mdir obj_dir -o tb_read_path
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_read_path > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
exit 0
